//--- common/cpu_pkg.sv
package cpu_pkg;

    // Machine data width
    localparam int XLEN = 32;

    // One data word as held in the register file
    typedef logic [XLEN-1:0] word_t;

    // Instruction address
    typedef logic [XLEN-1:0] pc_t;

    // Raw instruction word, always 32 bits for RV32I
    typedef logic [31:0] instr_t;

    // Register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

endpackage : cpu_pkg

//--- common/isa_pkg.sv
package isa_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 for register and immediate ALU ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 values that select ADD or SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ADDI x0,x0,0
    localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

endpackage : isa_pkg

//--- decode/decode.sv
`timescale 1ns/10ps

module decode import cpu_pkg::*; import isa_pkg::*; (
    input  logic     valid_i,
    input  instr_t   instr_i,
    input  pc_t      pc_i,
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    output logic     valid_o,
    output pc_t      pc_o,
    output alu_op_e  alu_op_o,
    output logic     use_imm_o,
    output word_t    imm_o,
    output reg_idx_t rd_o,
    output logic     rd_we_o,
    output logic     is_beq_o,
    output logic     is_bne_o,
    output logic     is_jal_o,
    output word_t    op_a_o,
    output word_t    op_b_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd_field;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    logic       known;

    assign opcode   = instr_i[6:0];
    assign rd_field = instr_i[11:7];
    assign funct3   = instr_i[14:12];
    assign funct7   = instr_i[31:25];

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        known     = 1'b1;
        alu_op_o  = ALU_ADD;
        use_imm_o = 1'b0;
        imm_o     = imm_i;
        rd_we_o   = 1'b0;
        is_beq_o  = 1'b0;
        is_bne_o  = 1'b0;
        is_jal_o  = 1'b0;
        case (opcode)
            OPC_OP: begin
                rd_we_o = 1'b1;
                if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    alu_op_o = ALU_SUB;
                end else if (funct7 != F7_BASE) begin
                    known = 1'b0;
                end else begin
                    case (funct3)
                        F3_ADD:  alu_op_o = ALU_ADD;
                        F3_XOR:  alu_op_o = ALU_XOR;
                        F3_OR:   alu_op_o = ALU_OR;
                        F3_AND:  alu_op_o = ALU_AND;
                        default: known = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                // Only ADDI from this group
                rd_we_o   = 1'b1;
                use_imm_o = 1'b1;
                known     = (funct3 == F3_ADD);
            end
            OPC_LUI: begin
                rd_we_o   = 1'b1;
                use_imm_o = 1'b1;
                alu_op_o  = ALU_PASS_B;
                imm_o     = imm_u;
            end
            OPC_BRANCH: begin
                imm_o    = imm_b;
                is_beq_o = (funct3 == F3_BEQ);
                is_bne_o = (funct3 == F3_BNE);
                known    = is_beq_o || is_bne_o;
            end
            OPC_JAL: begin
                rd_we_o  = 1'b1;
                is_jal_o = 1'b1;
                imm_o    = imm_j;
            end
            default: known = 1'b0;
        endcase
        // Unknown encodings leave as an invalid no-op
        if (!known) begin
            rd_we_o  = 1'b0;
            is_beq_o = 1'b0;
            is_bne_o = 1'b0;
            is_jal_o = 1'b0;
        end
    end

    assign valid_o = valid_i && known;
    assign pc_o    = pc_i;
    assign rd_o    = rd_we_o ? rd_field : '0;
    assign op_a_o  = rs1_data_i;
    assign op_b_o  = rs2_data_i;

endmodule : decode

//--- decode/regfile.sv
`timescale 1ns/10ps

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o,
    input  logic     we_i,
    input  reg_idx_t wr_idx_i,
    input  word_t    wr_data_i
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_idx_i != '0)) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // Write-through covers the writeback to decode hazard
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (we_i && (wr_idx_i == idx)) begin
            return wr_data_i;
        end
        return regs[idx];
    endfunction

    // Re-evaluated on any write port or storage change as well
    always_comb begin
        rs1_data_o = read_port(rs1_idx_i);
        rs2_data_o = read_port(rs2_idx_i);
    end

endmodule : regfile

//--- fetch/fetch.sv
`timescale 1ns/10ps

module fetch import cpu_pkg::*; #(
    parameter pc_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    output logic   imem_req_o,
    output pc_t    imem_addr_o,
    input  logic   imem_ack_i,
    input  instr_t imem_data_i,
    input  logic   redirect_i,
    input  pc_t    redirect_pc_i,
    output logic   instr_valid_o,
    output instr_t instr_o,
    output pc_t    pc_o
);

    typedef enum logic [1:0] {
        ISSUE,
        WAIT,
        DROP
    } fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;
    pc_t          pc_q;
    pc_t          pc_d;
    logic         run_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ISSUE;
            pc_q    <= RESET_PC;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            run_q   <= 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            ISSUE: begin
                // Request already stale if EXE redirects now
                if (imem_req_o) begin
                    state_d = redirect_i ? DROP : WAIT;
                end
            end
            WAIT: begin
                if (imem_ack_i) begin
                    state_d = ISSUE;
                    pc_d    = pc_q + pc_t'(4);
                end else if (redirect_i) begin
                    state_d = DROP;
                end
            end
            DROP: begin
                // Swallow the response to the wrong-path request
                if (imem_ack_i) begin
                    state_d = ISSUE;
                end
            end
            default: state_d = ISSUE;
        endcase
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end
    end

    // No request until the first cycle out of reset
    assign imem_req_o  = run_q && (state_q == ISSUE);
    assign imem_addr_o = pc_q;

    assign instr_valid_o = (state_q == WAIT) && imem_ack_i;
    assign instr_o       = imem_data_i;
    assign pc_o          = pc_q;

endmodule : fetch

//--- src.f
common/cpu_pkg.sv
common/isa_pkg.sv
src/stage_reg.sv
fetch/fetch.sv
decode/regfile.sv
decode/decode.sv
src/execute.sv
src/forward_flush.sv
src/pipeline_top.sv
tests/pipeline_chk.sv
tests/pipeline_tb.sv

//--- src/execute.sv
`timescale 1ns/10ps

module execute import cpu_pkg::*; import isa_pkg::*; (
    input  logic     valid_i,
    input  pc_t      pc_i,
    input  alu_op_e  alu_op_i,
    input  logic     use_imm_i,
    input  word_t    imm_i,
    input  word_t    op_a_i,
    input  word_t    op_b_i,
    input  reg_idx_t rd_i,
    input  logic     rd_we_i,
    input  logic     is_beq_i,
    input  logic     is_bne_i,
    input  logic     is_jal_i,
    input  logic     fwd_rs1_i,
    input  logic     fwd_rs2_i,
    input  word_t    wrb_data_i,
    output word_t    result_o,
    output logic     redirect_o,
    output pc_t      redirect_pc_o
);

    word_t rs1_val;
    word_t rs2_val;
    word_t alu_b;
    word_t alu_res;
    logic  operands_eq;
    logic  taken;

    // Operands captured in decode may be one instruction stale
    assign rs1_val = fwd_rs1_i ? wrb_data_i : op_a_i;
    assign rs2_val = fwd_rs2_i ? wrb_data_i : op_b_i;
    assign alu_b   = use_imm_i ? imm_i : rs2_val;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_res = rs1_val + alu_b;
            ALU_SUB:    alu_res = rs1_val - alu_b;
            ALU_AND:    alu_res = rs1_val & alu_b;
            ALU_OR:     alu_res = rs1_val | alu_b;
            ALU_XOR:    alu_res = rs1_val ^ alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch compare
    assign operands_eq = (rs1_val == rs2_val);
    assign taken = (is_beq_i && operands_eq) || (is_bne_i && !operands_eq) || is_jal_i;

    assign redirect_o    = valid_i && taken;
    assign redirect_pc_o = pc_i + imm_i;

    // Link address for JAL, zero when nothing is written
    always_comb begin
        if (!rd_we_i || rd_i == '0) begin
            result_o = '0;
        end else if (is_jal_i) begin
            result_o = pc_i + pc_t'(4);
        end else begin
            result_o = alu_res;
        end
    end

endmodule : execute

//--- src/forward_flush.sv
`timescale 1ns/10ps

module forward_flush import cpu_pkg::*; (
    input  reg_idx_t exe_rs1_i,
    input  reg_idx_t exe_rs2_i,
    input  reg_idx_t wrb_rd_i,
    input  logic     wrb_we_i,
    input  logic     wrb_valid_i,
    input  logic     fetch_valid_i,
    input  logic     redirect_i,
    output logic     fwd_rs1_o,
    output logic     fwd_rs2_o,
    output logic     flush_if2id_o,
    output logic     flush_id2exe_o
);

    logic wrb_writes;

    // x0 is never forwarded
    assign wrb_writes = wrb_valid_i && wrb_we_i && (wrb_rd_i != '0);

    assign fwd_rs1_o = wrb_writes && (wrb_rd_i == exe_rs1_i);
    assign fwd_rs2_o = wrb_writes && (wrb_rd_i == exe_rs2_i);

    // Taken branch kills the two younger stages;
    // an empty fetch cycle puts a bubble into decode
    assign flush_if2id_o  = redirect_i || !fetch_valid_i;
    assign flush_id2exe_o = redirect_i;

endmodule : forward_flush

//--- src/pipeline_top.sv
`timescale 1ns/10ps

module pipeline_top import cpu_pkg::*; import isa_pkg::*; #(
    parameter pc_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    output logic     imem_req_o,
    output pc_t      imem_addr_o,
    input  logic     imem_ack_i,
    input  instr_t   imem_data_i,
    output logic     commit_valid_o,
    output pc_t      commit_pc_o,
    output reg_idx_t commit_rd_o,
    output word_t    commit_data_o
);

    localparam int IF2ID_W   = 2 * XLEN + 1;
    localparam int ID2EXE_W  = 4 * XLEN + $bits(alu_op_e) + 3 * $bits(reg_idx_t) + 6;
    localparam int EXE2WRB_W = 2 * XLEN + $bits(reg_idx_t) + 2;

    logic     f_valid;
    instr_t   f_instr;
    pc_t      f_pc;
    logic     flush_if2id;
    logic     flush_id2exe;

    logic     id_valid;
    pc_t      id_pc;
    instr_t   id_instr;
    reg_idx_t d_rs1_idx;
    reg_idx_t d_rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     d_valid;
    pc_t      d_pc;
    alu_op_e  d_alu_op;
    logic     d_use_imm;
    word_t    d_imm;
    reg_idx_t d_rd;
    logic     d_rd_we;
    logic     d_is_beq;
    logic     d_is_bne;
    logic     d_is_jal;
    word_t    d_op_a;
    word_t    d_op_b;

    logic     ex_valid;
    pc_t      ex_pc;
    logic [$bits(alu_op_e)-1:0] ex_alu_op_bits;
    logic     ex_use_imm;
    word_t    ex_imm;
    reg_idx_t ex_rd;
    logic     ex_rd_we;
    logic     ex_is_beq;
    logic     ex_is_bne;
    logic     ex_is_jal;
    word_t    ex_op_a;
    word_t    ex_op_b;
    reg_idx_t ex_rs1_idx;
    reg_idx_t ex_rs2_idx;
    word_t    ex_result;
    logic     redirect;
    pc_t      redirect_pc;
    logic     fwd_rs1;
    logic     fwd_rs2;

    logic     wb_valid;
    pc_t      wb_pc;
    reg_idx_t wb_rd;
    logic     wb_rd_we;
    word_t    wb_data;

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_ack_i    (imem_ack_i),
        .imem_data_i   (imem_data_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .instr_valid_o (f_valid),
        .instr_o       (f_instr),
        .pc_o          (f_pc)
    );

    // Fetch to decode, bubble is an invalid NOP
    stage_reg #(
        .WIDTH   (IF2ID_W),
        .RST_VAL ({1'b0, {XLEN{1'b0}}, INSTR_NOP})
    ) if2id_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_if2id),
        .d_i     ({f_valid, f_pc, f_instr}),
        .q_o     ({id_valid, id_pc, id_instr})
    );

    decode u_decode (
        .valid_i    (id_valid),
        .instr_i    (id_instr),
        .pc_i       (id_pc),
        .rs1_idx_o  (d_rs1_idx),
        .rs2_idx_o  (d_rs2_idx),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .valid_o    (d_valid),
        .pc_o       (d_pc),
        .alu_op_o   (d_alu_op),
        .use_imm_o  (d_use_imm),
        .imm_o      (d_imm),
        .rd_o       (d_rd),
        .rd_we_o    (d_rd_we),
        .is_beq_o   (d_is_beq),
        .is_bne_o   (d_is_bne),
        .is_jal_o   (d_is_jal),
        .op_a_o     (d_op_a),
        .op_b_o     (d_op_b)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_idx_i  (d_rs1_idx),
        .rs2_idx_i  (d_rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid && wb_rd_we),
        .wr_idx_i   (wb_rd),
        .wr_data_i  (wb_data)
    );

    stage_reg #(
        .WIDTH   (ID2EXE_W),
        .RST_VAL ('0)
    ) id2exe_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_id2exe),
        .d_i     ({d_valid, d_pc, d_alu_op, d_use_imm, d_imm, d_rd, d_rd_we,
                   d_is_beq, d_is_bne, d_is_jal, d_op_a, d_op_b, d_rs1_idx, d_rs2_idx}),
        .q_o     ({ex_valid, ex_pc, ex_alu_op_bits, ex_use_imm, ex_imm, ex_rd, ex_rd_we,
                   ex_is_beq, ex_is_bne, ex_is_jal, ex_op_a, ex_op_b, ex_rs1_idx,
                   ex_rs2_idx})
    );

    execute u_execute (
        .valid_i       (ex_valid),
        .pc_i          (ex_pc),
        .alu_op_i      (alu_op_e'(ex_alu_op_bits)),
        .use_imm_i     (ex_use_imm),
        .imm_i         (ex_imm),
        .op_a_i        (ex_op_a),
        .op_b_i        (ex_op_b),
        .rd_i          (ex_rd),
        .rd_we_i       (ex_rd_we),
        .is_beq_i      (ex_is_beq),
        .is_bne_i      (ex_is_bne),
        .is_jal_i      (ex_is_jal),
        .fwd_rs1_i     (fwd_rs1),
        .fwd_rs2_i     (fwd_rs2),
        .wrb_data_i    (wb_data),
        .result_o      (ex_result),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    forward_flush u_forward_flush (
        .exe_rs1_i      (ex_rs1_idx),
        .exe_rs2_i      (ex_rs2_idx),
        .wrb_rd_i       (wb_rd),
        .wrb_we_i       (wb_rd_we),
        .wrb_valid_i    (wb_valid),
        .fetch_valid_i  (f_valid),
        .redirect_i     (redirect),
        .fwd_rs1_o      (fwd_rs1),
        .fwd_rs2_o      (fwd_rs2),
        .flush_if2id_o  (flush_if2id),
        .flush_id2exe_o (flush_id2exe)
    );

    // Writeback boundary, never flushed
    stage_reg #(
        .WIDTH   (EXE2WRB_W),
        .RST_VAL ('0)
    ) exe2wrb_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (1'b0),
        .d_i     ({ex_valid, ex_pc, ex_rd, ex_rd_we, ex_result}),
        .q_o     ({wb_valid, wb_pc, wb_rd, wb_rd_we, wb_data})
    );

    assign commit_valid_o = wb_valid;
    assign commit_pc_o    = wb_pc;
    assign commit_rd_o    = wb_rd;
    assign commit_data_o  = wb_data;

endmodule : pipeline_top

//--- src/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter int               WIDTH   = 1,
    parameter logic [WIDTH-1:0] RST_VAL = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush_i,
    input  logic [WIDTH-1:0] d_i,
    output logic [WIDTH-1:0] q_o
);

    // A flush turns the boundary into a bubble, same as reset
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            q_o <= RST_VAL;
        end else begin
            q_o <= d_i;
        end
    end

endmodule : stage_reg

//--- tests/pipeline_chk.sv
`timescale 1ns/10ps

module pipeline_chk import cpu_pkg::*; #(
    parameter pc_t RESET_PC = '0
) (
    input logic clk,
    input logic rst_n,
    input logic imem_req_i,
    input pc_t  imem_addr_i,
    input logic imem_ack_i,
    input logic commit_valid_i
);

    int   fail_count = 0;
    logic outstanding;

    // One instruction-memory request in flight at most
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (imem_req_i) begin
            outstanding <= 1'b1;
        end else if (imem_ack_i) begin
            outstanding <= 1'b0;
        end
    end

    // Core stays quiet for the whole reset and the cycle after it
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !commit_valid_i && !imem_req_i)
        else begin
            fail_count++;
            $error("request or commit while reset was held");
        end

    first_fetch: assert property (@(posedge clk)
        $rose(rst_n) |=> imem_req_i && (imem_addr_i == RESET_PC))
        else begin
            fail_count++;
            $error("first fetch after reset missing or not at the reset address");
        end

    single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !imem_req_i)
        else begin
            fail_count++;
            $error("new fetch request while one is still outstanding");
        end

endmodule : pipeline_chk

bind pipeline_top pipeline_chk #(
    .RESET_PC (RESET_PC)
) u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_i     (imem_req_o),
    .imem_addr_i    (imem_addr_o),
    .imem_ack_i     (imem_ack_i),
    .commit_valid_i (commit_valid_o)
);

//--- tests/pipeline_tb.sv
`timescale 1ns/10ps

module pipeline_tb import cpu_pkg::*; import isa_pkg::*; ();

    localparam pc_t RESET_PC       = '0;
    localparam int  NUM_COMMITS    = 21;
    localparam int  TIMEOUT_CYCLES = 2000;

    logic     clk;
    logic     rst_n;
    logic     imem_req_o;
    pc_t      imem_addr_o;
    logic     imem_ack_i;
    instr_t   imem_data_i;
    logic     commit_valid_o;
    pc_t      commit_pc_o;
    reg_idx_t commit_rd_o;
    word_t    commit_data_o;

    instr_t      imem [0:63];
    pc_t         exp_pc [NUM_COMMITS];
    reg_idx_t    exp_rd [NUM_COMMITS];
    word_t       exp_data [NUM_COMMITS];
    int          seen;
    int          errors;
    logic [31:0] lcg_state;
    logic        pending;
    int          wait_cnt;
    pc_t         req_addr;

    pipeline_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_ack_i     (imem_ack_i),
        .imem_data_i    (imem_data_i),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic instr_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                      input reg_idx_t rd, input reg_idx_t rs1,
                                      input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t addi(input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic instr_t branch(input logic [2:0] f3, input reg_idx_t rs1,
                                      input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t jal(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            // Filler tagged with its word address, opcode 7f is unknown
            imem[i] = {25'(i), 7'h7f};
        end
        imem[0]  = addi(5'd1, 5'd0, 12'd5);
        imem[1]  = addi(5'd2, 5'd1, 12'd7);
        imem[2]  = reg_op(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2);
        imem[3]  = reg_op(F7_SUB, F3_ADD, 5'd4, 5'd3, 5'd1);
        imem[4]  = reg_op(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd3);
        imem[5]  = reg_op(F7_BASE, F3_OR, 5'd6, 5'd4, 5'd3);
        imem[6]  = reg_op(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd2);
        imem[7]  = lui(5'd8, 20'h12345);
        imem[8]  = reg_op(F7_BASE, F3_ADD, 5'd8, 5'd8, 5'd7);
        // Write to x0, then read it back through x9
        imem[9]  = addi(5'd0, 5'd1, 12'd3);
        imem[10] = reg_op(F7_BASE, F3_ADD, 5'd9, 5'd0, 5'd1);
        imem[11] = 32'hffff_ffff;
        imem[12] = branch(F3_BEQ, 5'd2, 5'd4, 13'd12);
        imem[13] = addi(5'd10, 5'd0, 12'd99);
        imem[14] = addi(5'd11, 5'd0, 12'd99);
        imem[15] = branch(F3_BNE, 5'd1, 5'd1, 13'd8);
        imem[16] = branch(F3_BNE, 5'd1, 5'd2, 13'd12);
        imem[17] = addi(5'd10, 5'd0, 12'd1);
        imem[18] = addi(5'd11, 5'd0, 12'd1);
        imem[19] = branch(F3_BEQ, 5'd1, 5'd2, 13'd8);
        imem[20] = jal(5'd12, 21'd12);
        imem[21] = addi(5'd10, 5'd0, 12'd2);
        imem[22] = addi(5'd11, 5'd0, 12'd2);
        imem[23] = reg_op(F7_BASE, F3_ADD, 5'd13, 5'd12, 5'd9);
        // x31 must still be zero after the unknown word
        imem[24] = reg_op(F7_BASE, F3_ADD, 5'd14, 5'd31, 5'd1);
        imem[25] = jal(5'd0, 21'd0);
    endtask

    // In-order ISA model, one entry per committing instruction
    task automatic build_expected();
        word_t      regs [32];
        pc_t        pc;
        pc_t        next_pc;
        instr_t     ins;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      val;
        logic       commits;
        logic       writes;
        int         n;
        int         steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc    = RESET_PC;
        n     = 0;
        steps = 0;
        while (n < NUM_COMMITS && steps < 1000) begin
            ins     = imem[pc[7:2]];
            opc     = ins[6:0];
            rd      = ins[11:7];
            f3      = ins[14:12];
            f7      = ins[31:25];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            next_pc = pc + 32'd4;
            commits = 1'b1;
            writes  = 1'b0;
            val     = '0;
            case (opc)
                OPC_OP: begin
                    writes = 1'b1;
                    case ({f7, f3})
                        {F7_BASE, F3_ADD}: val = a + b;
                        {F7_SUB, F3_ADD}:  val = a - b;
                        {F7_BASE, F3_AND}: val = a & b;
                        {F7_BASE, F3_OR}:  val = a | b;
                        {F7_BASE, F3_XOR}: val = a ^ b;
                        default:           commits = 1'b0;
                    endcase
                end
                OPC_OP_IMM: begin
                    writes  = 1'b1;
                    commits = (f3 == F3_ADD);
                    val     = a + {{20{ins[31]}}, ins[31:20]};
                end
                OPC_LUI: begin
                    writes = 1'b1;
                    val    = {ins[31:12], 12'h000};
                end
                OPC_BRANCH: begin
                    commits = (f3 == F3_BEQ) || (f3 == F3_BNE);
                    if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    writes  = 1'b1;
                    val     = pc + 32'd4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: commits = 1'b0;
            endcase
            if (commits) begin
                exp_pc[n] = pc;
                if (writes && rd != '0) begin
                    regs[rd]    = val;
                    exp_rd[n]   = rd;
                    exp_data[n] = val;
                end else begin
                    exp_rd[n]   = '0;
                    exp_data[n] = '0;
                end
                n++;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory model, acknowledges 1 to 4 cycles after each request
    always @(negedge clk) begin
        imem_ack_i = 1'b0;
        if (!rst_n) begin
            pending  = 1'b0;
            wait_cnt = 0;
        end else begin
            if (pending) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    imem_ack_i  = 1'b1;
                    imem_data_i = imem[req_addr[7:2]];
                    pending     = 1'b0;
                end
            end
            if (imem_req_o) begin
                pending   = 1'b1;
                req_addr  = imem_addr_o;
                lcg_state = lcg_next(lcg_state);
                wait_cnt  = 1 + int'(lcg_state[17:16]);
            end
        end
    end

    // Commit outputs are registered, so they are steady at the falling edge
    always @(negedge clk) begin
        if (rst_n && commit_valid_o === 1'b1 && seen < NUM_COMMITS) begin
            assert (commit_pc_o === exp_pc[seen]) else begin
                errors++;
                $display("ERR %0t: commit %0d pc %h, expected %h", $time, seen,
                         commit_pc_o, exp_pc[seen]);
            end
            assert (commit_rd_o === exp_rd[seen]) else begin
                errors++;
                $display("ERR %0t: commit %0d rd %0d, expected %0d", $time, seen,
                         commit_rd_o, exp_rd[seen]);
            end
            assert (commit_data_o === exp_data[seen]) else begin
                errors++;
                $display("ERR %0t: commit %0d data %h, expected %h", $time, seen,
                         commit_data_o, exp_data[seen]);
            end
            seen++;
        end
    end

    initial begin
        int cycles;
        rst_n       = 1'b0;
        imem_ack_i  = 1'b0;
        imem_data_i = INSTR_NOP;
        seen        = 0;
        errors      = 0;
        lcg_state   = 32'h9734_091f;
        load_program();
        build_expected();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        cycles = 0;
        while (seen < NUM_COMMITS && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (seen < NUM_COMMITS) begin
            errors++;
            $display("Timeout waiting for commits: saw %0d of %0d in %0d cycles",
                     seen, NUM_COMMITS, cycles);
        end
        repeat (4) @(negedge clk);
        $display("Errors: %0d commit, %0d protocol", errors, UUT.u_chk.fail_count);
        if (errors == 0 && UUT.u_chk.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : pipeline_tb
